// File: rtc_map_pkg.sv
package rtc_map_pkg;

  // Registers touched by one adjust run
  localparam int num_slots = 10;

  // Bits per serial frame, address byte then data byte
  localparam int frame_bits = 16;

  typedef logic [3:0] slot_addr_t;
  typedef logic [7:0] reg_addr_t;
  typedef logic [7:0] data_t;

  ////////////////////////////////////////////////////////////////////////
  // Slot to chip register address
  ////////////////////////////////////////////////////////////////////////
  // Time and date fields first, then the timer block
  function automatic reg_addr_t chip_addr_of(slot_addr_t slot);
    reg_addr_t addr;
    addr = 8'h00;
    if (slot >= 4'd1 && slot <= 4'd7) begin
      addr = 8'h20 + {4'h0, slot};
    end else if (slot >= 4'd8 && slot <= 4'd10) begin
      addr = 8'h41 + {4'h0, slot - 4'd8};
    end
    return addr;
  endfunction

endpackage

// File: adjust_types_pkg.sv
package adjust_types_pkg;

  // Banks behind the loader: base, increment, decrement
  localparam int num_banks = 3;

  ////////////////////////////////////////////////////////////////////////
  // Host bank select code
  ////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    bank_base    = 2'd0,
    bank_inc     = 2'd1,
    bank_dec     = 2'd2,
    bank_illegal = 2'd3
  } bank_sel_t;

  ////////////////////////////////////////////////////////////////////////
  // Adjust sequencer states
  ////////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    st_idle    = 3'd0,
    st_compute = 3'd1,
    st_write   = 3'd2,
    st_advance = 3'd3,
    st_finish  = 3'd4
  } seq_state_t;

endpackage

// File: bank_loader.sv
`timescale 1ns/1ns

module bank_loader (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              load_strobe,
  input  adjust_types_pkg::bank_sel_t       load_bank,
  input  rtc_map_pkg::slot_addr_t           load_addr,
  input  rtc_map_pkg::data_t                load_data,
  input  logic                              busy,
  output logic [adjust_types_pkg::num_banks-1:0] bank_we,
  output rtc_map_pkg::slot_addr_t           wr_addr,
  output rtc_map_pkg::data_t                wr_data,
  output logic                              load_error
);
  import adjust_types_pkg::*;

  // Write address and data, captured on every strobe
  always_ff @(posedge clk) begin
    if (load_strobe) begin
      wr_addr <= load_addr;
      wr_data <= load_data;
    end
  end

  // One-hot enable, or an error pulse for a rejected write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_we    <= '0;
      load_error <= 1'b0;
    end else begin
      bank_we    <= '0;
      load_error <= 1'b0;
      if (load_strobe) begin
        if (load_bank == bank_illegal || busy) begin
          load_error <= 1'b1;
        end else begin
          bank_we[load_bank] <= 1'b1;
        end
      end
    end
  end

  a_we_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(bank_we));

endmodule

// File: value_bank.sv
`timescale 1ns/1ns

module value_bank (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    we,
  input  rtc_map_pkg::slot_addr_t wr_addr,
  input  rtc_map_pkg::data_t      wr_data,
  input  rtc_map_pkg::slot_addr_t rd_addr,
  output rtc_map_pkg::data_t      rd_data
);
  import rtc_map_pkg::*;

  localparam int depth = 16;

  data_t mem [depth];

  ////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////
  // All entries start at zero so an unloaded slot adds nothing
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port, no register
  assign rd_data = mem[rd_addr];

endmodule

// File: adjust_sequencer.sv
`timescale 1ns/1ns

module adjust_sequencer #(
  parameter int num_slots = rtc_map_pkg::num_slots
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  rtc_map_pkg::data_t      base_data,
  input  rtc_map_pkg::data_t      inc_data,
  input  rtc_map_pkg::data_t      dec_data,
  input  logic                    fin,
  output rtc_map_pkg::slot_addr_t rd_addr,
  output logic                    wr_req,
  output rtc_map_pkg::reg_addr_t  chip_addr,
  output rtc_map_pkg::data_t      chip_data,
  output logic                    busy,
  output logic                    done
);
  import rtc_map_pkg::*;
  import adjust_types_pkg::*;

  localparam slot_addr_t last_slot = slot_addr_t'(num_slots);

  seq_state_t state;
  seq_state_t next_state;
  slot_addr_t slot;

  ////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////
  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (start) begin
          next_state = st_compute;
        end
      end
      st_compute: begin
        next_state = st_write;
      end
      st_write: begin
        // Hold here until the port has sent the frame
        if (fin) begin
          next_state = st_advance;
        end
      end
      st_advance: begin
        if (slot == last_slot) begin
          next_state = st_finish;
        end else begin
          next_state = st_compute;
        end
      end
      st_finish: begin
        next_state = st_finish;
      end
      default: begin
        next_state = st_idle;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////
  // State, slot counter and outputs
  ////////////////////////////////////////////////////////////////////////
  // Start low acts like reset, so an abort lands back in idle at slot 1
  always_ff @(posedge clk) begin
    if (!rst_n || !start) begin
      state     <= st_idle;
      slot      <= 4'd1;
      wr_req    <= 1'b0;
      chip_addr <= '0;
      chip_data <= '0;
      done      <= 1'b0;
    end else begin
      state <= next_state;
      case (state)
        st_compute: begin
          // Modulo 256, no BCD fixup and no carry into the next field
          chip_data <= base_data - dec_data + inc_data;
          chip_addr <= chip_addr_of(slot);
          wr_req    <= 1'b1;
        end
        st_write: begin
          if (fin) begin
            wr_req <= 1'b0;
          end
        end
        st_advance: begin
          chip_addr <= '0;
          chip_data <= '0;
          slot      <= slot + 4'd1;
          if (slot == last_slot) begin
            done <= 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Banks are read only while the sum is being formed
  assign rd_addr = (state == st_compute) ? slot : '0;

  assign busy = (state == st_compute) || (state == st_write) || (state == st_advance);

  ////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////
  a_req_slot_range : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wr_req) |-> (slot != '0) && (slot <= last_slot));

  // Port shifts straight from these, they must hold for the whole frame
  a_req_payload_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (wr_req && $past(wr_req)) |-> ($stable(chip_data) && $stable(chip_addr)));

endmodule

// File: serial_write_port.sv
`timescale 1ns/1ns

module serial_write_port #(
  parameter int bit_div = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_req,
  input  rtc_map_pkg::reg_addr_t chip_addr,
  input  rtc_map_pkg::data_t     chip_data,
  output logic                   fin,
  output logic                   ser_cs_n,
  output logic                   ser_sck,
  output logic                   ser_sdo
);
  import rtc_map_pkg::*;

  localparam int div_w = $clog2(bit_div + 1);
  localparam int cnt_w = $clog2(frame_bits);

  logic [frame_bits-1:0] shreg;
  logic [div_w-1:0]      div_cnt;
  logic [cnt_w-1:0]      bit_cnt;
  logic                  active;
  logic                  half_tick;
  logic                  launch;

  // fin blocks a relaunch while wr_req is still high from the old frame
  assign launch    = !active && wr_req && !fin;
  assign half_tick = (div_cnt == div_w'(bit_div - 1));

  // MSB first, line parked low outside a frame
  assign ser_sdo = shreg[frame_bits-1] & ~ser_cs_n;

  always_ff @(posedge clk) begin
    if (launch) begin
      shreg <= {chip_addr, chip_data};
    end else if (active && half_tick && ser_sck) begin
      shreg <= {shreg[frame_bits-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Frame timing
  ////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active   <= 1'b0;
      ser_cs_n <= 1'b1;
      ser_sck  <= 1'b0;
      fin      <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
    end else begin
      fin <= 1'b0;
      if (launch) begin
        active   <= 1'b1;
        ser_cs_n <= 1'b0;
        div_cnt  <= '0;
        bit_cnt  <= '0;
      end else if (active && half_tick) begin
        div_cnt <= '0;
        ser_sck <= ~ser_sck;
        // Falling edge, next bit goes out
        if (ser_sck) begin
          bit_cnt <= bit_cnt + cnt_w'(1);
          if (bit_cnt == cnt_w'(frame_bits - 1)) begin
            active   <= 1'b0;
            ser_cs_n <= 1'b1;
            fin      <= 1'b1;
          end
        end
      end else if (active) begin
        div_cnt <= div_cnt + div_w'(1);
      end
    end
  end

  a_fin_after_frame : assert property (@(posedge clk) disable iff (!rst_n)
    fin |-> $past(active) && $past(!ser_cs_n));

endmodule

// File: time_adjust_top.sv
`timescale 1ns/1ns

module time_adjust_top #(
  parameter int num_slots = rtc_map_pkg::num_slots,
  parameter int bit_div   = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic                        load_strobe,
  input  adjust_types_pkg::bank_sel_t load_bank,
  input  rtc_map_pkg::slot_addr_t     load_addr,
  input  rtc_map_pkg::data_t          load_data,
  output logic                        ser_cs_n,
  output logic                        ser_sck,
  output logic                        ser_sdo,
  output logic                        done,
  output logic                        load_error,
  output logic                        busy
);
  import rtc_map_pkg::*;
  import adjust_types_pkg::*;

  logic [num_banks-1:0] bank_we;
  slot_addr_t           wr_addr;
  slot_addr_t           rd_addr;
  data_t                wr_data;
  data_t                bank_rd [num_banks];
  logic                 wr_req;
  logic                 fin;
  reg_addr_t            chip_addr;
  data_t                chip_data;

  bank_loader u_loader (
    .clk, .rst_n, .load_strobe, .load_bank, .load_addr, .load_data, .busy,
    .bank_we, .wr_addr, .wr_data, .load_error
  );

  ////////////////////////////////////////////////////////////////////////
  // Base, increment and decrement banks
  ////////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < num_banks; i++) begin : bank_g
    value_bank u_bank (
      .clk, .rst_n, .we(bank_we[i]), .wr_addr, .wr_data, .rd_addr,
      .rd_data(bank_rd[i])
    );
  end

  adjust_sequencer #(.num_slots(num_slots)) u_seq (
    .clk, .rst_n, .start,
    .base_data(bank_rd[bank_base]), .inc_data(bank_rd[bank_inc]),
    .dec_data(bank_rd[bank_dec]),
    .fin, .rd_addr, .wr_req, .chip_addr, .chip_data, .busy, .done
  );

  serial_write_port #(.bit_div(bit_div)) u_port (
    .clk, .rst_n, .wr_req, .chip_addr, .chip_data,
    .fin, .ser_cs_n, .ser_sck, .ser_sdo
  );

endmodule

// File: tb_time_adjust_top.sv
`timescale 1ns/1ns

module tb_time_adjust_top;
  import rtc_map_pkg::*;
  import adjust_types_pkg::*;

  localparam int run_limit = 4000;

  logic       clk;
  logic       rst_n;
  logic       start;
  logic       load_strobe;
  bank_sel_t  load_bank;
  slot_addr_t load_addr;
  data_t      load_data;
  logic       ser_cs_n;
  logic       ser_sck;
  logic       ser_sdo;
  logic       done;
  logic       load_error;
  logic       busy;

  int        error_count = 0;
  int        timeout_count = 0;
  logic [7:0] tdata [0:6*num_slots-1];
  reg_addr_t exp_addr [1:num_slots];
  data_t     exp_data [1:num_slots];

  logic [frame_bits-1:0] shift_in;
  logic [frame_bits-1:0] frames [$];
  logic                  in_frame = 1'b0;
  int                    bit_count;

  time_adjust_top #(.num_slots(num_slots), .bit_div(2)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Frame decoder, one frame per chip select low window
  //////////////////////////////////////////////////////////////////////
  always @(negedge ser_cs_n) begin
    in_frame  = 1'b1;
    bit_count = 0;
  end

  // Data moves while sck is low
  always @(posedge ser_sck) begin
    shift_in = {shift_in[frame_bits-2:0], ser_sdo};
    bit_count++;
  end

  always @(posedge ser_cs_n) begin
    if (in_frame) begin
      if (bit_count != frame_bits) begin
        error_count++;
        $display("Error frame sck edges: expected %0d, actual %0d", frame_bits, bit_count);
      end
      frames.push_back(shift_in);
      in_frame = 1'b0;
    end
  end

  // Slots 1 to 7 are time and date, 8 to 10 the timer block
  function automatic reg_addr_t expected_addr(slot_addr_t slot);
    case (slot)
      4'd1:    return 8'h21;
      4'd2:    return 8'h22;
      4'd3:    return 8'h23;
      4'd4:    return 8'h24;
      4'd5:    return 8'h25;
      4'd6:    return 8'h26;
      4'd7:    return 8'h27;
      4'd8:    return 8'h41;
      4'd9:    return 8'h42;
      4'd10:   return 8'h43;
      default: return 8'h00;
    endcase
  endfunction

  function automatic data_t expected_sum(data_t base, data_t inc, data_t dec);
    return data_t'(base + inc - dec);
  endfunction

  task automatic check_addr(string name, reg_addr_t expected, reg_addr_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("Error %s: expected %02h, actual %02h", name, expected, actual);
    end
  endtask

  task automatic check_data(string name, data_t expected, data_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("Error %s: expected %02h, actual %02h", name, expected, actual);
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      error_count++;
      $display("Error %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_count(string name, int expected, int actual);
    if (actual != expected) begin
      error_count++;
      $display("Error %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic drive_load(bank_sel_t bank, slot_addr_t addr, data_t data);
    @(negedge clk);
    load_strobe = 1'b1;
    load_bank   = bank;
    load_addr   = addr;
    load_data   = data;
    @(negedge clk);
    load_strobe = 1'b0;
  endtask

  task automatic check_frames(string name, int count);
    for (int i = 0; i < count && i < num_slots; i++) begin
      check_addr($sformatf("%s slot %0d address", name, i + 1), exp_addr[i+1], frames[i][15:8]);
      check_data($sformatf("%s slot %0d data", name, i + 1), exp_data[i+1], frames[i][7:0]);
    end
  endtask

  task automatic load_file_banks;
    int         r;
    slot_addr_t slot;
    for (int row = 0; row < num_slots; row++) begin
      r    = row * 6;
      slot = slot_addr_t'(tdata[r]);
      drive_load(bank_base, slot, tdata[r+1]);
      drive_load(bank_inc, slot, tdata[r+2]);
      drive_load(bank_dec, slot, tdata[r+3]);
      check_flag($sformatf("file row %0d load error", row), 1'b0, load_error);
      check_addr($sformatf("file row %0d address", row), expected_addr(slot), tdata[r+4]);
      check_data($sformatf("file row %0d data", row),
                 expected_sum(tdata[r+1], tdata[r+2], tdata[r+3]), tdata[r+5]);
      exp_addr[slot] = tdata[r+4];
      exp_data[slot] = tdata[r+5];
    end
  endtask

  task automatic load_random;
    data_t b;
    data_t i;
    data_t d;
    for (int s = 1; s <= num_slots; s++) begin
      b = data_t'($urandom);
      i = data_t'($urandom);
      d = data_t'($urandom);
      drive_load(bank_base, slot_addr_t'(s), b);
      drive_load(bank_inc, slot_addr_t'(s), i);
      drive_load(bank_dec, slot_addr_t'(s), d);
      exp_addr[s] = expected_addr(slot_addr_t'(s));
      exp_data[s] = expected_sum(b, i, d);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Complete run, optionally with a rejected load while busy
  //////////////////////////////////////////////////////////////////////
  task automatic run_full(string name, bit busy_load);
    int cycles;
    frames.delete();
    @(negedge clk);
    start = 1'b1;
    if (busy_load) begin
      cycles = 0;
      while (busy !== 1'b1 && cycles < run_limit) begin
        @(negedge clk);
        cycles++;
      end
      if (busy !== 1'b1) begin
        timeout_count++;
        $display("Timeout in %s: busy never rose", name);
      end
      drive_load(bank_base, 4'd2, 8'h55);
      check_flag({name, " busy load error"}, 1'b1, load_error);
    end
    cycles = 0;
    while (done !== 1'b1 && cycles < run_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      timeout_count++;
      $display("Timeout in %s: done never rose", name);
    end
    check_count({name, " frame count"}, num_slots, frames.size());
    check_frames(name, frames.size());
    repeat (20) begin
      @(negedge clk);
      check_flag({name, " done held"}, 1'b1, done);
    end
    start = 1'b0;
    @(negedge clk);
    check_flag({name, " done cleared"}, 1'b0, done);
    check_flag({name, " busy cleared"}, 1'b0, busy);
  endtask

  task automatic run_abort(string name, int stop_after);
    int   cycles;
    logic done_seen;
    frames.delete();
    done_seen = 1'b0;
    @(negedge clk);
    start  = 1'b1;
    cycles = 0;
    while (frames.size() < stop_after && cycles < run_limit) begin
      @(negedge clk);
      done_seen = done_seen | done;
      cycles++;
    end
    if (frames.size() < stop_after) begin
      timeout_count++;
      $display("Timeout in %s: only %0d frames seen", name, frames.size());
    end
    // Abort with the next frame on the wire, that frame still completes
    cycles = 0;
    while (ser_cs_n !== 1'b0 && cycles < run_limit) begin
      @(negedge clk);
      done_seen = done_seen | done;
      cycles++;
    end
    if (ser_cs_n !== 1'b0) begin
      timeout_count++;
      $display("Timeout in %s: next frame never started", name);
    end
    start  = 1'b0;
    cycles = 0;
    while (ser_cs_n !== 1'b1 && cycles < run_limit) begin
      @(negedge clk);
      done_seen = done_seen | done;
      cycles++;
    end
    if (ser_cs_n !== 1'b1) begin
      timeout_count++;
      $display("Timeout in %s: chip select stuck low", name);
    end
    // Quiet window, longer than one frame
    repeat (200) begin
      @(negedge clk);
      done_seen = done_seen | done;
    end
    check_count({name, " frame count"}, stop_after + 1, frames.size());
    check_flag({name, " done stayed low"}, 1'b0, done_seen);
    check_frames(name, frames.size());
  endtask

  initial begin
    void'($urandom(32'h53f5_3300));
    rst_n       = 1'b0;
    start       = 1'b0;
    load_strobe = 1'b0;
    load_bank   = bank_base;
    load_addr   = '0;
    load_data   = '0;
    $readmemh("time_adjust_testdata.txt", tdata);
    if ($isunknown(tdata[0])) begin
      error_count++;
      $display("Could not read stimulus from time_adjust_testdata.txt");
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_flag("reset ser_cs_n", 1'b1, ser_cs_n);
    check_flag("reset done", 1'b0, done);
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset load_error", 1'b0, load_error);

    load_file_banks();
    run_full("full run", 1'b0);
    run_abort("abort", 3);
    run_full("restart after abort", 1'b0);

    // Code 3 aims at slot 1, which must keep its file value
    drive_load(bank_illegal, 4'd1, 8'haa);
    check_flag("bank code 3 load error", 1'b1, load_error);
    run_full("illegal loads", 1'b1);

    load_random();
    run_full("random reload", 1'b0);

    $display("%0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: time_adjust_testdata.txt
// Columns: slot base increment decrement expected_address expected_data
// Expected data is base - decrement + increment, modulo 256
// Time and date fields
01 30 05 02 21 33
02 59 03 00 22 5c
// Underflow, 10 - 20 wraps
03 10 00 20 23 f0
// Overflow, f0 + 20 wraps
04 f0 20 00 24 10
05 07 01 01 25 07
06 12 00 00 26 12
07 25 80 10 27 95
// Timer block
// Overflow with both sides at the top
08 ff ff 00 41 fe
// Underflow from zero
09 00 00 01 42 ff
// Overflow after a decrement
0a 80 90 05 43 0b

// File: time_adjust_top.f
rtc_map_pkg.sv
adjust_types_pkg.sv
bank_loader.sv
value_bank.sv
adjust_sequencer.sv
serial_write_port.sv
time_adjust_top.sv
tb_time_adjust_top.sv

// File: Bender.yml
package:
  name: time_adjust

sources:
  - rtc_map_pkg.sv
  - adjust_types_pkg.sv
  - bank_loader.sv
  - value_bank.sv
  - adjust_sequencer.sv
  - serial_write_port.sv
  - time_adjust_top.sv
  - target: test
    files:
      - tb_time_adjust_top.sv
